//--- source/rcfg_pkg.sv
/*
 * Transceiver reconfiguration debug package
 * Bus widths, the soft register map and the bit positions of the
 * overridable channel controls
 */
package rcfg_pkg;

  localparam int ADDR_BITS      = 10;
  localparam int DATA_WIDTH     = 32;
  localparam int CHNL_DATA_BITS = 8;
  localparam int CSR_SEL_BIT    = 9;
  localparam int PRBS_CNT_BITS  = 50;

  // Soft register offsets below the CSR select bit
  typedef enum logic [8:0] {
    CSR_ID        = 9'h000,
    CSR_STATUS    = 9'h001,
    CSR_CTRL_EN   = 9'h002,
    CSR_CTRL_VAL  = 9'h003,
    CSR_CAL_MASK  = 9'h004,
    CSR_PRBS_CTRL = 9'h005,
    // Error snapshot, least significant byte first
    CSR_PRBS_ERR0 = 9'h006,
    CSR_PRBS_ERR1 = 9'h007,
    CSR_PRBS_ERR2 = 9'h008,
    CSR_PRBS_ERR3 = 9'h009,
    CSR_PRBS_ERR4 = 9'h00A,
    CSR_PRBS_ERR5 = 9'h00B,
    CSR_PRBS_ERR6 = 9'h00C,
    // Bit snapshot
    CSR_PRBS_BIT0 = 9'h00D,
    CSR_PRBS_BIT1 = 9'h00E,
    CSR_PRBS_BIT2 = 9'h00F,
    CSR_PRBS_BIT3 = 9'h010,
    CSR_PRBS_BIT4 = 9'h011,
    CSR_PRBS_BIT5 = 9'h012,
    CSR_PRBS_BIT6 = 9'h013
  } csr_addr_e;

  // Bit positions in the override enable and value registers
  typedef enum logic [2:0] {
    CTRL_SET_RX_LOCKTOREF  = 3'd0,
    CTRL_SET_RX_LOCKTODATA = 3'd1,
    CTRL_EN_SERIAL_LPBK    = 3'd2,
    CTRL_RX_ANALOGRESET    = 3'd3,
    CTRL_RX_DIGITALRESET   = 3'd4,
    CTRL_TX_ANALOGRESET    = 3'd5,
    CTRL_TX_DIGITALRESET   = 3'd6
  } ctrl_bit_e;

endpackage

//--- source/rcfg_chan_split.sv
/*
 * Channel splitter for the shared reconfiguration port
 * The upper address bits pick a channel. Strobes go out one-hot, and the
 * selected channel's byte and waitrequest come back on the 32-bit bus.
 * A select past the last channel reads zero without waiting.
 */
`timescale 1ns/10ps

module rcfg_chan_split
  import rcfg_pkg::*;
#(
  parameter int CHANNELS = 4,
  localparam int SEL_BITS = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  logic                             reconfig_write,
  input  logic                             reconfig_read,
  input  logic [ADDR_BITS+SEL_BITS-1:0]    reconfig_address,
  input  logic [DATA_WIDTH-1:0]            reconfig_writedata,
  output logic [DATA_WIDTH-1:0]            reconfig_readdata,
  output logic                             reconfig_waitrequest,
  output logic [CHANNELS-1:0]              chan_write,
  output logic [CHANNELS-1:0]              chan_read,
  output logic [ADDR_BITS-1:0]             chan_address,
  output logic [CHNL_DATA_BITS-1:0]        chan_writedata,
  input  logic [CHANNELS*CHNL_DATA_BITS-1:0] chan_readdata,
  input  logic [CHANNELS-1:0]              chan_waitrequest
);

  logic [SEL_BITS-1:0]       sel;
  logic [CHNL_DATA_BITS-1:0] sel_byte;
  logic                      sel_wait;

  assign sel            = reconfig_address[ADDR_BITS +: SEL_BITS];
  assign chan_address   = reconfig_address[ADDR_BITS-1:0];
  assign chan_writedata = reconfig_writedata[CHNL_DATA_BITS-1:0];

  // An unmatched select leaves all strobes low and the response at zero
  always_comb begin
    sel_byte = '0;
    sel_wait = 1'b0;
    for (int i = 0; i < CHANNELS; i++) begin
      chan_write[i] = reconfig_write & (sel == i);
      chan_read[i]  = reconfig_read & (sel == i);
      if (sel == i) begin
        sel_byte = chan_readdata[i*CHNL_DATA_BITS +: CHNL_DATA_BITS];
        sel_wait = chan_waitrequest[i];
      end
    end
  end

  assign reconfig_readdata    = {{(DATA_WIDTH-CHNL_DATA_BITS){1'b0}}, sel_byte};
  assign reconfig_waitrequest = sel_wait;

endmodule

//--- source/prbs_accum.sv
/*
 * PRBS error accumulator
 * Counts checked bits and errored bits while enabled, copies both into
 * snapshot registers on request and registers the checker done flag.
 */
`timescale 1ns/10ps

module prbs_accum
  import rcfg_pkg::*;
(
  input  logic                     reconfig_clk,
  input  logic                     rst,
  input  logic                     clear,
  input  logic                     snap,
  input  logic                     count_en,
  input  logic                     prbs_err_signal,
  input  logic                     prbs_done_signal,
  output logic [PRBS_CNT_BITS-1:0] err_snap,
  output logic [PRBS_CNT_BITS-1:0] bit_snap,
  output logic                     done
);

  logic [PRBS_CNT_BITS-1:0] err_cnt;
  logic [PRBS_CNT_BITS-1:0] bit_cnt;

  always_ff @(posedge reconfig_clk) begin
    if (rst || clear) begin
      err_cnt <= '0;
      bit_cnt <= '0;
    end else if (count_en) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (prbs_err_signal)
        err_cnt <= err_cnt + 1'b1;
    end
  end

  // Clear wins over a snapshot in the same cycle
  always_ff @(posedge reconfig_clk) begin
    if (rst || clear) begin
      err_snap <= '0;
      bit_snap <= '0;
    end else if (snap) begin
      err_snap <= err_cnt;
      bit_snap <= bit_cnt;
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (rst)
      done <= 1'b0;
    else
      done <= prbs_done_signal;
  end

endmodule

//--- source/rcfg_soft_csr.sv
/*
 * Soft register block of one channel
 * Reports status, overrides the reset, lock and loopback controls, holds
 * the cal-busy masks and drives the PRBS accumulator. Every access takes
 * one wait state, readdata is registered.
 */
`timescale 1ns/10ps

module rcfg_soft_csr
  import rcfg_pkg::*;
#(
  parameter logic [7:0] USER_ID = 8'h00
) (
  input  logic                      reconfig_clk,
  input  logic                      rst,
  input  logic                      write,
  input  logic                      read,
  input  logic [CSR_SEL_BIT-1:0]    address,
  input  logic [CHNL_DATA_BITS-1:0] writedata,
  output logic [CHNL_DATA_BITS-1:0] readdata,
  output logic                      waitrequest,
  input  logic                      in_rx_is_lockedtoref,
  input  logic                      in_rx_is_lockedtodata,
  input  logic                      in_tx_cal_busy,
  input  logic                      in_rx_cal_busy,
  input  logic                      in_avmm_busy,
  input  logic                      in_rx_prbs_err_clr,
  input  logic                      in_set_rx_locktoref,
  input  logic                      in_set_rx_locktodata,
  input  logic                      in_en_serial_lpbk,
  input  logic                      in_rx_analogreset,
  input  logic                      in_rx_digitalreset,
  input  logic                      in_tx_analogreset,
  input  logic                      in_tx_digitalreset,
  output logic                      out_prbs_err_clr,
  output logic                      out_set_rx_locktoref,
  output logic                      out_set_rx_locktodata,
  output logic                      out_en_serial_lpbk,
  output logic                      out_rx_analogreset,
  output logic                      out_rx_digitalreset,
  output logic                      out_tx_analogreset,
  output logic                      out_tx_digitalreset,
  output logic                      out_tx_cal_busy_mask,
  output logic                      out_rx_cal_busy_mask,
  output logic                      prbs_count_en,
  output logic                      prbs_snap,
  output logic                      prbs_clear,
  input  logic [PRBS_CNT_BITS-1:0]  prbs_err_snap,
  input  logic [PRBS_CNT_BITS-1:0]  prbs_bit_snap,
  input  logic                      prbs_done
);

  logic                      ack;
  logic                      wr_done;
  logic                      rd_start;
  logic [6:0]                ctrl_en;
  logic [6:0]                ctrl_val;
  logic [6:0]                ctrl_in;
  logic [6:0]                ctrl_out;
  logic [55:0]               err_ext;
  logic [55:0]               bit_ext;
  logic [CHNL_DATA_BITS-1:0] rd_next;

  // First cycle of a request waits, the second completes it
  assign waitrequest = (read | write) & ~ack;
  assign wr_done     = write & ack;
  assign rd_start    = read & ~ack;

  // Snapshots padded out to whole bytes
  assign err_ext = {{(56-PRBS_CNT_BITS){1'b0}}, prbs_err_snap};
  assign bit_ext = {{(56-PRBS_CNT_BITS){1'b0}}, prbs_bit_snap};

  always_ff @(posedge reconfig_clk) begin
    if (rst) begin
      ack                  <= 1'b0;
      ctrl_en              <= '0;
      ctrl_val             <= '0;
      out_tx_cal_busy_mask <= 1'b1;
      out_rx_cal_busy_mask <= 1'b1;
      prbs_count_en        <= 1'b0;
      prbs_clear           <= 1'b0;
      prbs_snap            <= 1'b0;
    end else begin
      ack        <= (read | write) & ~ack;
      prbs_clear <= 1'b0;
      prbs_snap  <= 1'b0;
      if (wr_done) begin
        case (address)
          CSR_CTRL_EN:  ctrl_en <= writedata[6:0];
          CSR_CTRL_VAL: ctrl_val <= writedata[6:0];
          CSR_CAL_MASK: begin
            out_tx_cal_busy_mask <= writedata[0];
            out_rx_cal_busy_mask <= writedata[1];
          end
          CSR_PRBS_CTRL: begin
            prbs_count_en <= writedata[0];
            prbs_clear    <= writedata[1];
            prbs_snap     <= writedata[2];
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rd_next = '0;
    case (address)
      CSR_ID:        rd_next = USER_ID;
      CSR_STATUS:    rd_next = {3'b000, in_avmm_busy, in_rx_cal_busy, in_tx_cal_busy,
                                in_rx_is_lockedtodata, in_rx_is_lockedtoref};
      CSR_CTRL_EN:   rd_next = {1'b0, ctrl_en};
      CSR_CTRL_VAL:  rd_next = {1'b0, ctrl_val};
      CSR_CAL_MASK:  rd_next = {6'd0, out_rx_cal_busy_mask, out_tx_cal_busy_mask};
      CSR_PRBS_CTRL: rd_next = {4'd0, prbs_done, 2'b00, prbs_count_en};
      default: begin
        if (address >= CSR_PRBS_ERR0 && address <= CSR_PRBS_ERR6)
          rd_next = err_ext[8*(address - CSR_PRBS_ERR0) +: 8];
        else if (address >= CSR_PRBS_BIT0 && address <= CSR_PRBS_BIT6)
          rd_next = bit_ext[8*(address - CSR_PRBS_BIT0) +: 8];
      end
    endcase
  end

  // Captured in the wait cycle, valid in the completion cycle
  always_ff @(posedge reconfig_clk) begin
    if (rd_start)
      readdata <= rd_next;
  end

  assign ctrl_in[CTRL_SET_RX_LOCKTOREF]  = in_set_rx_locktoref;
  assign ctrl_in[CTRL_SET_RX_LOCKTODATA] = in_set_rx_locktodata;
  assign ctrl_in[CTRL_EN_SERIAL_LPBK]    = in_en_serial_lpbk;
  assign ctrl_in[CTRL_RX_ANALOGRESET]    = in_rx_analogreset;
  assign ctrl_in[CTRL_RX_DIGITALRESET]   = in_rx_digitalreset;
  assign ctrl_in[CTRL_TX_ANALOGRESET]    = in_tx_analogreset;
  assign ctrl_in[CTRL_TX_DIGITALRESET]   = in_tx_digitalreset;

  // Enabled bits take the value register, the rest pass through
  assign ctrl_out = (ctrl_en & ctrl_val) | (~ctrl_en & ctrl_in);

  assign out_set_rx_locktoref  = ctrl_out[CTRL_SET_RX_LOCKTOREF];
  assign out_set_rx_locktodata = ctrl_out[CTRL_SET_RX_LOCKTODATA];
  assign out_en_serial_lpbk    = ctrl_out[CTRL_EN_SERIAL_LPBK];
  assign out_rx_analogreset    = ctrl_out[CTRL_RX_ANALOGRESET];
  assign out_rx_digitalreset   = ctrl_out[CTRL_RX_DIGITALRESET];
  assign out_tx_analogreset    = ctrl_out[CTRL_TX_ANALOGRESET];
  assign out_tx_digitalreset   = ctrl_out[CTRL_TX_DIGITALRESET];
  assign out_prbs_err_clr      = in_rx_prbs_err_clr | prbs_clear;

endmodule

//--- source/rcfg_chan_slice.sv
/*
 * Per-channel reconfiguration slice
 * Address bit 9 steers an access to the hard channel bus or to the soft
 * register block. Also holds the channel's PRBS accumulator.
 */
`timescale 1ns/10ps

module rcfg_chan_slice
  import rcfg_pkg::*;
#(
  parameter logic [7:0] USER_ID = 8'h00
) (
  input  logic                      reconfig_clk,
  input  logic                      rst,
  input  logic                      write,
  input  logic                      read,
  input  logic [ADDR_BITS-1:0]      address,
  input  logic [CHNL_DATA_BITS-1:0] writedata,
  output logic [CHNL_DATA_BITS-1:0] readdata,
  output logic                      waitrequest,
  // Hard channel bus
  output logic                      avmm_write,
  output logic                      avmm_read,
  output logic [ADDR_BITS-1:0]      avmm_address,
  output logic [CHNL_DATA_BITS-1:0] avmm_writedata,
  input  logic [CHNL_DATA_BITS-1:0] avmm_readdata,
  input  logic                      avmm_waitrequest,
  input  logic                      prbs_err_signal,
  input  logic                      prbs_done_signal,
  // Status
  input  logic                      in_rx_is_lockedtoref,
  input  logic                      in_rx_is_lockedtodata,
  input  logic                      in_tx_cal_busy,
  input  logic                      in_rx_cal_busy,
  input  logic                      in_avmm_busy,
  // Controls
  input  logic                      in_rx_prbs_err_clr,
  input  logic                      in_set_rx_locktoref,
  input  logic                      in_set_rx_locktodata,
  input  logic                      in_en_serial_lpbk,
  input  logic                      in_rx_analogreset,
  input  logic                      in_rx_digitalreset,
  input  logic                      in_tx_analogreset,
  input  logic                      in_tx_digitalreset,
  output logic                      out_prbs_err_clr,
  output logic                      out_set_rx_locktoref,
  output logic                      out_set_rx_locktodata,
  output logic                      out_en_serial_lpbk,
  output logic                      out_rx_analogreset,
  output logic                      out_rx_digitalreset,
  output logic                      out_tx_analogreset,
  output logic                      out_tx_digitalreset,
  output logic                      out_tx_cal_busy_mask,
  output logic                      out_rx_cal_busy_mask
);

  logic                      csr_sel;
  logic                      csr_write;
  logic                      csr_read;
  logic [CHNL_DATA_BITS-1:0] csr_readdata;
  logic                      csr_waitrequest;
  logic                      prbs_count_en;
  logic                      prbs_snap;
  logic                      prbs_clear;
  logic [PRBS_CNT_BITS-1:0]  prbs_err_snap;
  logic [PRBS_CNT_BITS-1:0]  prbs_bit_snap;
  logic                      prbs_done;

  assign csr_sel   = address[CSR_SEL_BIT];
  assign csr_write = write & csr_sel;
  assign csr_read  = read & csr_sel;

  // Hard channel sees only accesses below the soft register window
  assign avmm_write     = write & ~csr_sel;
  assign avmm_read      = read & ~csr_sel;
  assign avmm_address   = address;
  assign avmm_writedata = writedata;

  assign readdata    = csr_sel ? csr_readdata : avmm_readdata;
  assign waitrequest = csr_sel ? csr_waitrequest : avmm_waitrequest;

  // Status and control ports share their names with this module's ports
  rcfg_soft_csr #(
    .USER_ID     (USER_ID)
  ) u_soft_csr (
    .*,
    .write       (csr_write),
    .read        (csr_read),
    .address     (address[CSR_SEL_BIT-1:0]),
    .readdata    (csr_readdata),
    .waitrequest (csr_waitrequest)
  );

  prbs_accum u_prbs_accum (
    .reconfig_clk     (reconfig_clk),
    .rst              (rst),
    .clear            (prbs_clear),
    .snap             (prbs_snap),
    .count_en         (prbs_count_en),
    .prbs_err_signal  (prbs_err_signal),
    .prbs_done_signal (prbs_done_signal),
    .err_snap         (prbs_err_snap),
    .bit_snap         (prbs_bit_snap),
    .done             (prbs_done)
  );

endmodule

//--- source/xcvr_rcfg_debug_top.sv
/*
 * Transceiver reconfiguration debug wrapper
 * Splits the shared reconfiguration port across the channels and gives
 * each channel its own soft registers and PRBS accumulator.
 */
`timescale 1ns/10ps

module xcvr_rcfg_debug_top
  import rcfg_pkg::*;
#(
  parameter int         CHANNELS = 4,
  parameter logic [7:0] USER_ID  = 8'h00,
  localparam int        SEL_BITS = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  logic                               reconfig_clk,
  input  logic                               rst,
  input  logic                               reconfig_write,
  input  logic                               reconfig_read,
  input  logic [ADDR_BITS+SEL_BITS-1:0]      reconfig_address,
  input  logic [DATA_WIDTH-1:0]              reconfig_writedata,
  output logic [DATA_WIDTH-1:0]              reconfig_readdata,
  output logic                               reconfig_waitrequest,
  output logic [CHANNELS-1:0]                avmm_write,
  output logic [CHANNELS-1:0]                avmm_read,
  output logic [CHANNELS*ADDR_BITS-1:0]      avmm_address,
  output logic [CHANNELS*CHNL_DATA_BITS-1:0] avmm_writedata,
  input  logic [CHANNELS*CHNL_DATA_BITS-1:0] avmm_readdata,
  input  logic [CHANNELS-1:0]                avmm_waitrequest,
  input  logic [CHANNELS-1:0]                prbs_err_signal,
  input  logic [CHANNELS-1:0]                prbs_done_signal,
  input  logic [CHANNELS-1:0]                in_rx_is_lockedtoref,
  input  logic [CHANNELS-1:0]                in_rx_is_lockedtodata,
  input  logic [CHANNELS-1:0]                in_tx_cal_busy,
  input  logic [CHANNELS-1:0]                in_rx_cal_busy,
  input  logic [CHANNELS-1:0]                in_avmm_busy,
  input  logic [CHANNELS-1:0]                in_rx_prbs_err_clr,
  input  logic [CHANNELS-1:0]                in_set_rx_locktoref,
  input  logic [CHANNELS-1:0]                in_set_rx_locktodata,
  input  logic [CHANNELS-1:0]                in_en_serial_lpbk,
  input  logic [CHANNELS-1:0]                in_rx_analogreset,
  input  logic [CHANNELS-1:0]                in_rx_digitalreset,
  input  logic [CHANNELS-1:0]                in_tx_analogreset,
  input  logic [CHANNELS-1:0]                in_tx_digitalreset,
  output logic [CHANNELS-1:0]                out_prbs_err_clr,
  output logic [CHANNELS-1:0]                out_set_rx_locktoref,
  output logic [CHANNELS-1:0]                out_set_rx_locktodata,
  output logic [CHANNELS-1:0]                out_en_serial_lpbk,
  output logic [CHANNELS-1:0]                out_rx_analogreset,
  output logic [CHANNELS-1:0]                out_rx_digitalreset,
  output logic [CHANNELS-1:0]                out_tx_analogreset,
  output logic [CHANNELS-1:0]                out_tx_digitalreset,
  output logic [CHANNELS-1:0]                out_tx_cal_busy_mask,
  output logic [CHANNELS-1:0]                out_rx_cal_busy_mask
);

  logic [CHANNELS-1:0]                chan_write;
  logic [CHANNELS-1:0]                chan_read;
  logic [ADDR_BITS-1:0]               chan_address;
  logic [CHNL_DATA_BITS-1:0]          chan_writedata;
  logic [CHANNELS*CHNL_DATA_BITS-1:0] chan_readdata;
  logic [CHANNELS-1:0]                chan_waitrequest;

  rcfg_chan_split #(
    .CHANNELS (CHANNELS)
  ) u_split (
    .*
  );

  for (genvar i = 0; i < CHANNELS; i++) begin : g_chan
    rcfg_chan_slice #(
      .USER_ID (USER_ID)
    ) u_slice (
      .reconfig_clk          (reconfig_clk),
      .rst                   (rst),
      .write                 (chan_write[i]),
      .read                  (chan_read[i]),
      .address               (chan_address),
      .writedata             (chan_writedata),
      .readdata              (chan_readdata[i*CHNL_DATA_BITS +: CHNL_DATA_BITS]),
      .waitrequest           (chan_waitrequest[i]),
      .avmm_write            (avmm_write[i]),
      .avmm_read             (avmm_read[i]),
      .avmm_address          (avmm_address[i*ADDR_BITS +: ADDR_BITS]),
      .avmm_writedata        (avmm_writedata[i*CHNL_DATA_BITS +: CHNL_DATA_BITS]),
      .avmm_readdata         (avmm_readdata[i*CHNL_DATA_BITS +: CHNL_DATA_BITS]),
      .avmm_waitrequest      (avmm_waitrequest[i]),
      .prbs_err_signal       (prbs_err_signal[i]),
      .prbs_done_signal      (prbs_done_signal[i]),
      .in_rx_is_lockedtoref  (in_rx_is_lockedtoref[i]),
      .in_rx_is_lockedtodata (in_rx_is_lockedtodata[i]),
      .in_tx_cal_busy        (in_tx_cal_busy[i]),
      .in_rx_cal_busy        (in_rx_cal_busy[i]),
      .in_avmm_busy          (in_avmm_busy[i]),
      .in_rx_prbs_err_clr    (in_rx_prbs_err_clr[i]),
      .in_set_rx_locktoref   (in_set_rx_locktoref[i]),
      .in_set_rx_locktodata  (in_set_rx_locktodata[i]),
      .in_en_serial_lpbk     (in_en_serial_lpbk[i]),
      .in_rx_analogreset     (in_rx_analogreset[i]),
      .in_rx_digitalreset    (in_rx_digitalreset[i]),
      .in_tx_analogreset     (in_tx_analogreset[i]),
      .in_tx_digitalreset    (in_tx_digitalreset[i]),
      .out_prbs_err_clr      (out_prbs_err_clr[i]),
      .out_set_rx_locktoref  (out_set_rx_locktoref[i]),
      .out_set_rx_locktodata (out_set_rx_locktodata[i]),
      .out_en_serial_lpbk    (out_en_serial_lpbk[i]),
      .out_rx_analogreset    (out_rx_analogreset[i]),
      .out_rx_digitalreset   (out_rx_digitalreset[i]),
      .out_tx_analogreset    (out_tx_analogreset[i]),
      .out_tx_digitalreset   (out_tx_digitalreset[i]),
      .out_tx_cal_busy_mask  (out_tx_cal_busy_mask[i]),
      .out_rx_cal_busy_mask  (out_rx_cal_busy_mask[i])
    );
  end

endmodule

//--- test/tb_xcvr_rcfg_debug.sv
/*
 * Testbench for the transceiver reconfiguration debug wrapper
 * Drives the shared reconfiguration port against a model of four hard
 * channels. Checks the channel split, back-pressure, soft registers,
 * control overrides and the PRBS accumulator.
 */
`timescale 1ns/10ps

module tb_xcvr_rcfg_debug
  import rcfg_pkg::*;
();

  localparam int         CHANNELS = 4;
  localparam logic [7:0] USER_ID  = 8'h5A;
  localparam int         AW       = ADDR_BITS + 2;

  logic                               reconfig_clk;
  logic                               rst;
  logic                               reconfig_write;
  logic                               reconfig_read;
  logic [AW-1:0]                      reconfig_address;
  logic [DATA_WIDTH-1:0]              reconfig_writedata;
  logic [DATA_WIDTH-1:0]              reconfig_readdata;
  logic                               reconfig_waitrequest;
  logic [CHANNELS-1:0]                avmm_write;
  logic [CHANNELS-1:0]                avmm_read;
  logic [CHANNELS*ADDR_BITS-1:0]      avmm_address;
  logic [CHANNELS*CHNL_DATA_BITS-1:0] avmm_writedata;
  logic [CHANNELS*CHNL_DATA_BITS-1:0] avmm_readdata;
  logic [CHANNELS-1:0]                avmm_waitrequest;
  logic [CHANNELS-1:0]                prbs_err_signal, prbs_done_signal;
  logic [CHANNELS-1:0]                in_rx_is_lockedtoref, in_rx_is_lockedtodata;
  logic [CHANNELS-1:0]                in_tx_cal_busy, in_rx_cal_busy, in_avmm_busy;
  logic [CHANNELS-1:0]                in_rx_prbs_err_clr, in_set_rx_locktoref;
  logic [CHANNELS-1:0]                in_set_rx_locktodata, in_en_serial_lpbk;
  logic [CHANNELS-1:0]                in_rx_analogreset, in_rx_digitalreset;
  logic [CHANNELS-1:0]                in_tx_analogreset, in_tx_digitalreset;
  logic [CHANNELS-1:0]                out_prbs_err_clr, out_set_rx_locktoref;
  logic [CHANNELS-1:0]                out_set_rx_locktodata, out_en_serial_lpbk;
  logic [CHANNELS-1:0]                out_rx_analogreset, out_rx_digitalreset;
  logic [CHANNELS-1:0]                out_tx_analogreset, out_tx_digitalreset;
  logic [CHANNELS-1:0]                out_tx_cal_busy_mask, out_rx_cal_busy_mask;

  // Channel model state
  int wait_cnt [CHANNELS];
  int wait_len [CHANNELS];

  int errors = 0;
  int checks = 0;

  // Expected register contents per channel
  logic [6:0] en_m   [CHANNELS];
  logic [6:0] val_m  [CHANNELS];
  logic [1:0] mask_m [CHANNELS];

  // Hard bus as seen in the completion cycle of the last access
  logic [CHANNELS-1:0]                seen_write;
  logic [CHANNELS*ADDR_BITS-1:0]      seen_addr;
  logic [CHANNELS*CHNL_DATA_BITS-1:0] seen_wdata;

  logic [CHANNELS-1:0] sel_hot;
  logic                hard_sel;

  xcvr_rcfg_debug_top #(
    .CHANNELS (CHANNELS),
    .USER_ID  (USER_ID)
  ) dut (
    .*
  );

  initial reconfig_clk = 1'b0;
  always #10 reconfig_clk = ~reconfig_clk;

  // Each channel stalls a new access for 0 to 3 cycles
  always @(posedge reconfig_clk) begin
    for (int k = 0; k < CHANNELS; k++) begin
      if (avmm_read[k] || avmm_write[k]) begin
        if (wait_cnt[k] < wait_len[k])
          wait_cnt[k] <= wait_cnt[k] + 1;
      end else begin
        wait_cnt[k] <= 0;
        wait_len[k] <= $urandom_range(3, 0);
      end
    end
  end

  for (genvar k = 0; k < CHANNELS; k++) begin : g_model
    assign avmm_readdata[k*8 +: 8] = 8'(k * 16) | {4'h0, avmm_address[k*ADDR_BITS +: 4]};
    assign avmm_waitrequest[k]     = (avmm_read[k] | avmm_write[k]) &&
                                     (wait_cnt[k] < wait_len[k]);
  end

  assign sel_hot  = 4'b0001 << reconfig_address[AW-1 -: 2];
  assign hard_sel = ~reconfig_address[CSR_SEL_BIT];

  // Strobes reach the selected hard channel only
  write_route: assert property (@(posedge reconfig_clk) disable iff (rst)
    avmm_write == ((reconfig_write && hard_sel) ? sel_hot : 4'b0000))
    else begin
      errors++;
      $display("ERROR %0t: avmm_write %b for address %h", $time, avmm_write, reconfig_address);
    end

  read_route: assert property (@(posedge reconfig_clk) disable iff (rst)
    avmm_read == ((reconfig_read && hard_sel) ? sel_hot : 4'b0000))
    else begin
      errors++;
      $display("ERROR %0t: avmm_read %b for address %h", $time, avmm_read, reconfig_address);
    end

  back_pressure: assert property (@(posedge reconfig_clk) disable iff (rst)
    ((reconfig_read || reconfig_write) && hard_sel)
      |-> (reconfig_waitrequest == avmm_waitrequest[reconfig_address[AW-1 -: 2]]))
    else begin
      errors++;
      $display("ERROR %0t: waitrequest does not follow channel %0d", $time,
               reconfig_address[AW-1 -: 2]);
    end

  task automatic check_eq(input string what, input int ch, input logic [63:0] got,
                          input logic [63:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("ERROR %0t: %s on channel %0d, got %0h expected %0h",
                 $time, what, ch, got, exp);
      end
  endtask

  function automatic logic [AW-1:0] hard_addr(input int ch, input logic [8:0] off);
    return {2'(ch), 1'b0, off};
  endfunction

  function automatic logic [AW-1:0] csr_addr(input int ch, input logic [8:0] off);
    return {2'(ch), 1'b1, off};
  endfunction

  task automatic bus_access(input logic is_write, input logic [AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge reconfig_clk);
    #2;
    reconfig_write     = is_write;
    reconfig_read      = ~is_write;
    reconfig_address   = addr;
    reconfig_writedata = wdata;
    // Held until the slave drops waitrequest
    @(negedge reconfig_clk);
    while (reconfig_waitrequest)
      @(negedge reconfig_clk);
    rdata      = reconfig_readdata;
    seen_write = avmm_write;
    seen_addr  = avmm_address;
    seen_wdata = avmm_writedata;
    @(posedge reconfig_clk);
    #2;
    reconfig_write = 1'b0;
    reconfig_read  = 1'b0;
  endtask

  task automatic bus_write(input logic [AW-1:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [AW-1:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, 32'h0, rdata);
  endtask

  task automatic read_snapshots(input int ch, output logic [55:0] err_v,
                                output logic [55:0] bit_v);
    logic [31:0] rd;
    for (int i = 0; i < 7; i++) begin
      bus_read(csr_addr(ch, 9'(CSR_PRBS_ERR0 + i)), rd);
      err_v[8*i +: 8] = rd[7:0];
      bus_read(csr_addr(ch, 9'(CSR_PRBS_BIT0 + i)), rd);
      bit_v[8*i +: 8] = rd[7:0];
    end
  endtask

  task automatic randomize_inputs();
    @(posedge reconfig_clk);
    #2;
    in_rx_is_lockedtoref  = $urandom();
    in_rx_is_lockedtodata = $urandom();
    in_tx_cal_busy        = $urandom();
    in_rx_cal_busy        = $urandom();
    in_avmm_busy          = $urandom();
    in_rx_prbs_err_clr    = $urandom();
    in_set_rx_locktoref   = $urandom();
    in_set_rx_locktodata  = $urandom();
    in_en_serial_lpbk     = $urandom();
    in_rx_analogreset     = $urandom();
    in_rx_digitalreset    = $urandom();
    in_tx_analogreset     = $urandom();
    in_tx_digitalreset    = $urandom();
  endtask

  // Bit order of the override registers
  function automatic logic [6:0] ctrl_inputs(input int ch);
    return {in_tx_digitalreset[ch], in_tx_analogreset[ch], in_rx_digitalreset[ch],
            in_rx_analogreset[ch], in_en_serial_lpbk[ch], in_set_rx_locktodata[ch],
            in_set_rx_locktoref[ch]};
  endfunction

  function automatic logic [6:0] ctrl_outputs(input int ch);
    return {out_tx_digitalreset[ch], out_tx_analogreset[ch], out_rx_digitalreset[ch],
            out_rx_analogreset[ch], out_en_serial_lpbk[ch], out_set_rx_locktodata[ch],
            out_set_rx_locktoref[ch]};
  endfunction

  task automatic check_controls();
    logic [6:0] exp;
    logic [6:0] in_v;
    @(negedge reconfig_clk);
    for (int ch = 0; ch < CHANNELS; ch++) begin
      in_v = ctrl_inputs(ch);
      for (int b = 0; b < 7; b++)
        exp[b] = en_m[ch][b] ? val_m[ch][b] : in_v[b];
      check_eq("control outputs", ch, ctrl_outputs(ch), exp);
      check_eq("cal-busy masks", ch,
               {out_rx_cal_busy_mask[ch], out_tx_cal_busy_mask[ch]}, mask_m[ch]);
      check_eq("prbs error clear", ch, out_prbs_err_clr[ch], in_rx_prbs_err_clr[ch]);
    end
  endtask

  // Budget of about 400 accesses at up to 8 cycles, with margin for PRBS counting
  initial begin
    #200us;
    $display("Timeout: the tests did not finish within 200 us, %0d errors so far", errors);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [8:0]  off;
    logic [55:0] err_a, bit_a, err_b, bit_b;
    int          n;
    void'($urandom(67));
    rst                = 1'b1;
    reconfig_write     = 1'b0;
    reconfig_read      = 1'b0;
    reconfig_address   = '0;
    reconfig_writedata = '0;
    prbs_err_signal    = '0;
    prbs_done_signal   = '0;
    {in_rx_is_lockedtoref, in_rx_is_lockedtodata, in_tx_cal_busy} = '0;
    {in_rx_cal_busy, in_avmm_busy, in_rx_prbs_err_clr} = '0;
    {in_set_rx_locktoref, in_set_rx_locktodata, in_en_serial_lpbk} = '0;
    {in_rx_analogreset, in_rx_digitalreset} = '0;
    {in_tx_analogreset, in_tx_digitalreset} = '0;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      en_m[ch]   = '0;
      val_m[ch]  = '0;
      mask_m[ch] = 2'b11;
    end
    repeat (10) @(posedge reconfig_clk);
    #2;
    rst = 1'b0;

    // Controls pass through after reset
    randomize_inputs();
    check_controls();

    // Hard channel writes and reads through the split
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int i = 0; i < 3; i++) begin
        off   = $urandom_range(511, 0);
        wdata = $urandom();
        bus_write(hard_addr(ch, off), wdata);
        check_eq("hard write strobe", ch, seen_write, 4'b0001 << ch);
        check_eq("hard write address", ch, seen_addr[ch*ADDR_BITS +: ADDR_BITS], {1'b0, off});
        check_eq("hard write data", ch, seen_wdata[ch*8 +: 8], wdata[7:0]);
        bus_read(hard_addr(ch, off), rdata);
        check_eq("hard read data", ch, rdata, ch * 16 + off[3:0]);
      end
    end

    // Soft register reads
    randomize_inputs();
    for (int ch = 0; ch < CHANNELS; ch++) begin
      bus_read(csr_addr(ch, CSR_ID), rdata);
      check_eq("user id", ch, rdata, USER_ID);
      bus_read(csr_addr(ch, CSR_STATUS), rdata);
      check_eq("status", ch, rdata, {in_avmm_busy[ch], in_rx_cal_busy[ch], in_tx_cal_busy[ch],
                                     in_rx_is_lockedtodata[ch], in_rx_is_lockedtoref[ch]});
      bus_read(csr_addr(ch, 9'($urandom_range(511, 20))), rdata);
      check_eq("unmapped offset", ch, rdata, 0);
    end

    // Control overrides and cal-busy masks
    for (int ch = 0; ch < CHANNELS; ch++) begin
      en_m[ch]  = $urandom();
      val_m[ch] = $urandom();
      bus_write(csr_addr(ch, CSR_CTRL_EN), en_m[ch]);
      bus_write(csr_addr(ch, CSR_CTRL_VAL), val_m[ch]);
      bus_read(csr_addr(ch, CSR_CTRL_EN), rdata);
      check_eq("override enable readback", ch, rdata, en_m[ch]);
    end
    randomize_inputs();
    check_controls();
    for (int ch = 0; ch < CHANNELS; ch++) begin
      mask_m[ch] = $urandom_range(3, 0);
      bus_write(csr_addr(ch, CSR_CAL_MASK), mask_m[ch]);
    end
    check_controls();

    // PRBS accumulator with errors held high on the even channels
    @(posedge reconfig_clk);
    #2;
    prbs_err_signal  = 4'b0101;
    prbs_done_signal = $urandom();
    for (int ch = 0; ch < CHANNELS; ch++) begin
      bus_write(csr_addr(ch, CSR_PRBS_CTRL), 32'h2);
      bus_write(csr_addr(ch, CSR_PRBS_CTRL), 32'h1);
      n = $urandom_range(40, 5);
      repeat (n) @(posedge reconfig_clk);
      // Snapshot taken while the counters keep running
      bus_write(csr_addr(ch, CSR_PRBS_CTRL), 32'h5);
      read_snapshots(ch, err_a, bit_a);
      check_eq("bit snapshot is nonzero", ch, bit_a != 0, 1);
      check_eq("error snapshot", ch, err_a, prbs_err_signal[ch] ? bit_a : 56'h0);
      read_snapshots(ch, err_b, bit_b);
      check_eq("repeated error snapshot", ch, err_b, err_a);
      check_eq("repeated bit snapshot", ch, bit_b, bit_a);
      bus_read(csr_addr(ch, CSR_PRBS_CTRL), rdata);
      check_eq("prbs control readback", ch, rdata, {prbs_done_signal[ch], 3'b001});
      bus_write(csr_addr(ch, CSR_PRBS_CTRL), 32'h2);
      read_snapshots(ch, err_b, bit_b);
      check_eq("error snapshot after clear", ch, err_b, 0);
      check_eq("bit snapshot after clear", ch, bit_b, 0);
    end

    repeat (5) @(posedge reconfig_clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- files.f
source/rcfg_pkg.sv
source/rcfg_chan_split.sv
source/prbs_accum.sv
source/rcfg_soft_csr.sv
source/rcfg_chan_slice.sv
source/xcvr_rcfg_debug_top.sv
test/tb_xcvr_rcfg_debug.sv
